/* logic/loop_pkt_pkg.sv */
// loop scheduler shared types

`default_nettype none

package loop_pkt_pkg;

    // ========================================================================
    // word geometry
    // ========================================================================
    parameter int DATA_BYTES = 64;
    parameter int SIDE_W     = 28;
    parameter int WORD_W     = SIDE_W + DATA_BYTES * 8;
    parameter int HDR_W      = 256;

    // eop flag, sideband bit 7
    parameter int EOP_BIT    = 519;

    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [DATA_BYTES*8-1:0] payload_t;
    typedef logic [HDR_W-1:0]        hdr_t;

    // one write beat towards a packet queue
    typedef struct packed {
        logic  wen;
        logic  wend;
        word_t wdata;
    } pkt_wr_t;

    // receive merge FSM
    typedef enum logic {
        RX_IDLE,
        RX_BODY
    } rx_state_e;

    // ========================================================================
    // payload byte reversal
    // ========================================================================
    // byte 0 goes to byte 63, sideband passes through
    function automatic word_t byte_swap(input word_t w);
        payload_t p_in;
        payload_t p_out;
        p_in = w[DATA_BYTES*8-1:0];
        for (int i = 0; i < DATA_BYTES; i++) begin
            p_out[(DATA_BYTES-1-i)*8 +: 8] = p_in[i*8 +: 8];
        end
        return {w[WORD_W-1 -: SIDE_W], p_out};
    endfunction

endpackage

`default_nettype wire

/* logic/sync_fifo.sv */
// first-word-fall-through fifo

`default_nettype none

module sync_fifo #(
    parameter int WIDTH    = 540,
    parameter int DEPTH    = 64,
    parameter int AF_LEVEL = 60
) (
    input  wire logic             clk_sys,
    input  wire logic             rst,

    // write side
    input  wire logic             wen,
    input  wire logic [WIDTH-1:0] wdata,

    // read side, rdata valid while ef is low
    input  wire logic             rd,
    output logic      [WIDTH-1:0] rdata,
    output logic                  ef,
    output logic                  aff
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_ok;
    logic             rd_ok;

    // drop writes into a full buffer, ignore reads from an empty one
    assign wr_ok = wen && (count != CW'(DEPTH));
    assign rd_ok = rd && (count != '0);

    always_ff @(posedge clk_sys) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // oldest entry shown directly
    assign rdata = mem[rd_ptr];
    assign ef    = (count == '0);
    assign aff   = (count >= CW'(AF_LEVEL));

endmodule

`default_nettype wire

/* logic/tx_port_steer.sv */
// transmit port steering

`default_nettype none

module tx_port_steer (
    input  wire logic                 clk_sys,
    input  wire logic                 rst,

    // ve to ae queue, fwft
    output logic                      ve2ae_rd,
    input  wire loop_pkt_pkg::word_t  ve2ae_rdata,
    input  wire logic                 ve2ae_ef,

    // static route, 0 loop and 1 mac
    input  wire logic                 loop_port_cfg,

    // loop fifo write
    output loop_pkt_pkg::pkt_wr_t     loop_wr,
    input  wire logic                 loop_aff,

    // mac fifo write
    output loop_pkt_pkg::pkt_wr_t     mac_wr,
    input  wire logic                 mac_aff,

    output logic                      port_lock
);

    logic                dest_aff;
    logic                rd_req;
    logic                rd_eop;
    loop_pkt_pkg::word_t swap_q;
    logic                loop_wen;
    logic                loop_wend;
    logic                mac_wen;
    logic                mac_wend;

    // ========================================================================
    // read request
    // ========================================================================
    // almost-full of whichever port is currently locked
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            dest_aff <= 1'b0;
        end else begin
            dest_aff <= port_lock ? mac_aff : loop_aff;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= !ve2ae_ef && !dest_aff;
        end
    end

    assign ve2ae_rd = rd_req && !ve2ae_ef;
    assign rd_eop   = ve2ae_rd && ve2ae_rdata[loop_pkt_pkg::EOP_BIT];

    // route changes only between packets
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            port_lock <= 1'b0;
        end else if (rd_eop) begin
            port_lock <= loop_port_cfg;
        end
    end

    // ========================================================================
    // write stage
    // ========================================================================
    always_ff @(posedge clk_sys) begin
        swap_q <= loop_pkt_pkg::byte_swap(ve2ae_rdata);
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            loop_wen  <= 1'b0;
            loop_wend <= 1'b0;
            mac_wen   <= 1'b0;
            mac_wend  <= 1'b0;
        end else begin
            loop_wen  <= ve2ae_rd && !port_lock;
            loop_wend <= rd_eop && !port_lock;
            mac_wen   <= ve2ae_rd && port_lock;
            mac_wend  <= rd_eop && port_lock;
        end
    end

    // same data to both, strobes pick the target
    assign loop_wr.wen   = loop_wen;
    assign loop_wr.wend  = loop_wend;
    assign loop_wr.wdata = swap_q;

    assign mac_wr.wen    = mac_wen;
    assign mac_wr.wend   = mac_wend;
    assign mac_wr.wdata  = swap_q;

endmodule

`default_nettype wire

/* logic/rx_pkt_merge.sv */
// receive header merge

`default_nettype none

module rx_pkt_merge (
    input  wire logic                 clk_sys,
    input  wire logic                 rst,

    input  wire logic                 port_lock,

    // result header fifo
    output logic                      hdr_rd,
    input  wire loop_pkt_pkg::hdr_t   hdr_rdata,
    input  wire logic                 hdr_ef,

    // loop fifo read
    output logic                      loop_rd,
    input  wire loop_pkt_pkg::word_t  loop_rdata,
    input  wire logic                 loop_ef,

    // mac fifo read
    output logic                      mac_rd,
    input  wire loop_pkt_pkg::word_t  mac_rdata,
    input  wire logic                 mac_ef,

    // ae to ve queue
    output loop_pkt_pkg::pkt_wr_t     ae2ve_wr,
    input  wire logic                 ae2ve_ff
);

    loop_pkt_pkg::rx_state_e state;
    logic                    src_mac;
    logic                    lock_ef;
    logic                    src_ef;
    loop_pkt_pkg::word_t     src_rdata;
    loop_pkt_pkg::word_t     hdr_word;
    logic                    start;
    logic                    body_rd;
    logic                    body_eop;
    logic                    out_wen;
    logic                    out_wend;
    loop_pkt_pkg::word_t     out_data;

    // ========================================================================
    // source select
    // ========================================================================
    // idle looks at the live lock, body sticks to the latched port
    assign lock_ef   = port_lock ? mac_ef : loop_ef;
    assign src_ef    = src_mac ? mac_ef : loop_ef;
    assign src_rdata = src_mac ? mac_rdata : loop_rdata;

    // header sits in the low payload bits, sideband zero
    assign hdr_word = {{(loop_pkt_pkg::WORD_W - loop_pkt_pkg::HDR_W){1'b0}}, hdr_rdata};

    assign start    = (state == loop_pkt_pkg::RX_IDLE) && !hdr_ef && !lock_ef && !ae2ve_ff;
    assign body_rd  = (state == loop_pkt_pkg::RX_BODY) && !src_ef && !ae2ve_ff;
    assign body_eop = body_rd && src_rdata[loop_pkt_pkg::EOP_BIT];

    assign hdr_rd  = start;
    assign loop_rd = body_rd && !src_mac;
    assign mac_rd  = body_rd && src_mac;

    // ========================================================================
    // FSM
    // ========================================================================
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            state   <= loop_pkt_pkg::RX_IDLE;
            src_mac <= 1'b0;
        end else begin
            case (state)
                loop_pkt_pkg::RX_IDLE: begin
                    if (start) begin
                        state   <= loop_pkt_pkg::RX_BODY;
                        src_mac <= port_lock;
                    end
                end
                loop_pkt_pkg::RX_BODY: begin
                    if (body_eop) begin
                        state <= loop_pkt_pkg::RX_IDLE;
                    end
                end
                default: state <= loop_pkt_pkg::RX_IDLE;
            endcase
        end
    end

    // ========================================================================
    // output register
    // ========================================================================
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            out_wen  <= 1'b0;
            out_wend <= 1'b0;
        end else begin
            out_wen  <= start || body_rd;
            out_wend <= body_eop;
        end
    end

    // header first, then body words swapped back
    always_ff @(posedge clk_sys) begin
        if (start) begin
            out_data <= loop_pkt_pkg::byte_swap(hdr_word);
        end else begin
            out_data <= loop_pkt_pkg::byte_swap(src_rdata);
        end
    end

    assign ae2ve_wr.wen   = out_wen;
    assign ae2ve_wr.wend  = out_wend;
    assign ae2ve_wr.wdata = out_data;

endmodule

`default_nettype wire

/* logic/loop_pkt_sch.sv */
// loopback packet scheduler

`default_nettype none

module loop_pkt_sch #(
    parameter int LOOP_DEPTH    = 64,
    parameter int LOOP_AF_LEVEL = 60,
    parameter int HDR_DEPTH     = 16,
    parameter int HDR_AF_LEVEL  = 12
) (
    input  wire logic                 clk_sys,
    input  wire logic                 rst,

    // result headers
    input  wire logic                 rlt_hd_wen,
    input  wire loop_pkt_pkg::hdr_t   rlt_hd_wdata,
    output logic                      rlt_hd_afull,

    // ve to ae queue
    output logic                      ve2ae_rd,
    input  wire loop_pkt_pkg::word_t  ve2ae_rdata,
    input  wire logic                 ve2ae_ef,

    // external mac fifo
    output loop_pkt_pkg::pkt_wr_t     mac_wr,
    input  wire logic                 mac_aff,
    output logic                      mac_rd,
    input  wire loop_pkt_pkg::word_t  mac_rdata,
    input  wire logic                 mac_ef,

    // ae to ve queue
    output loop_pkt_pkg::pkt_wr_t     ae2ve_wr,
    input  wire logic                 ae2ve_ff,

    input  wire logic                 loop_port_cfg
);

    loop_pkt_pkg::pkt_wr_t loop_wr;
    logic                  loop_aff;
    logic                  loop_rd;
    loop_pkt_pkg::word_t   loop_rdata;
    logic                  loop_ef;
    logic                  hdr_rd;
    loop_pkt_pkg::hdr_t    hdr_rdata;
    logic                  hdr_ef;
    logic                  port_lock;

    // ========================================================================
    // fifos
    // ========================================================================
    // eop rides in the word itself, so only wen and wdata are stored
    sync_fifo #(
        .WIDTH    (loop_pkt_pkg::WORD_W),
        .DEPTH    (LOOP_DEPTH),
        .AF_LEVEL (LOOP_AF_LEVEL)
    ) u_loop_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wen     (loop_wr.wen),
        .wdata   (loop_wr.wdata),
        .rd      (loop_rd),
        .rdata   (loop_rdata),
        .ef      (loop_ef),
        .aff     (loop_aff)
    );

    sync_fifo #(
        .WIDTH    (loop_pkt_pkg::HDR_W),
        .DEPTH    (HDR_DEPTH),
        .AF_LEVEL (HDR_AF_LEVEL)
    ) u_hdr_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wen     (rlt_hd_wen),
        .wdata   (rlt_hd_wdata),
        .rd      (hdr_rd),
        .rdata   (hdr_rdata),
        .ef      (hdr_ef),
        .aff     (rlt_hd_afull)
    );

    // ========================================================================
    // datapaths
    // ========================================================================
    tx_port_steer u_tx_port_steer (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .ve2ae_rd      (ve2ae_rd),
        .ve2ae_rdata   (ve2ae_rdata),
        .ve2ae_ef      (ve2ae_ef),
        .loop_port_cfg (loop_port_cfg),
        .loop_wr       (loop_wr),
        .loop_aff      (loop_aff),
        .mac_wr        (mac_wr),
        .mac_aff       (mac_aff),
        .port_lock     (port_lock)
    );

    rx_pkt_merge u_rx_pkt_merge (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .port_lock  (port_lock),
        .hdr_rd     (hdr_rd),
        .hdr_rdata  (hdr_rdata),
        .hdr_ef     (hdr_ef),
        .loop_rd    (loop_rd),
        .loop_rdata (loop_rdata),
        .loop_ef    (loop_ef),
        .mac_rd     (mac_rd),
        .mac_rdata  (mac_rdata),
        .mac_ef     (mac_ef),
        .ae2ve_wr   (ae2ve_wr),
        .ae2ve_ff   (ae2ve_ff)
    );

endmodule

`default_nettype wire

/* sim/loop_pkt_sch_checker.sv */
// scheduler protocol assertions

`default_nettype none

module loop_pkt_sch_checker (
    input wire logic                  clk_sys,
    input wire logic                  rst,
    input wire logic                  ve2ae_rd,
    input wire logic                  ve2ae_ef,
    input wire logic                  hdr_rd,
    input wire logic                  hdr_ef,
    input wire logic                  loop_rd,
    input wire logic                  loop_ef,
    input wire logic                  mac_rd,
    input wire logic                  mac_ef,
    input wire logic                  port_lock,
    input wire loop_pkt_pkg::pkt_wr_t mac_wr,
    input wire loop_pkt_pkg::pkt_wr_t ae2ve_wr,
    input wire logic                  ae2ve_ff
);

    // no read strobe against an empty fifo
    a_rd_not_empty: assert property (@(posedge clk_sys) disable iff (rst)
        (!ve2ae_rd || !ve2ae_ef) && (!hdr_rd || !hdr_ef)
        && (!loop_rd || !loop_ef) && (!mac_rd || !mac_ef))
        else $error("read strobe with empty flag high");

    a_ae_room: assert property (@(posedge clk_sys) disable iff (rst)
        ae2ve_wr.wen |-> $past(!ae2ve_ff))
        else $error("ae2ve write one cycle after full");

    // lock may leave mac only with the last word of a packet
    a_mac_locked: assert property (@(posedge clk_sys) disable iff (rst)
        mac_wr.wen && !mac_wr.wend |-> port_lock)
        else $error("mac write of a non-last word while the lock selects loop");

    a_reset_quiet: assert property (@(posedge clk_sys)
        rst && $past(rst) |-> !ve2ae_rd && !hdr_rd && !loop_rd && !mac_rd
            && !mac_wr.wen && !ae2ve_wr.wen)
        else $error("activity during reset");

endmodule

bind loop_pkt_sch loop_pkt_sch_checker u_checker (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .ve2ae_rd  (ve2ae_rd),
    .ve2ae_ef  (ve2ae_ef),
    .hdr_rd    (hdr_rd),
    .hdr_ef    (hdr_ef),
    .loop_rd   (loop_rd),
    .loop_ef   (loop_ef),
    .mac_rd    (mac_rd),
    .mac_ef    (mac_ef),
    .port_lock (port_lock),
    .mac_wr    (mac_wr),
    .ae2ve_wr  (ae2ve_wr),
    .ae2ve_ff  (ae2ve_ff)
);

`default_nettype wire

/* sim/loop_pkt_sch_tb.sv */
// loop scheduler testbench

`default_nettype none

module loop_pkt_sch_tb;

    localparam int NUM_PKTS  = 20;
    localparam int EARLY_HDR = 12;

    // one table row, exp_mac says whether the packet must show on mac_wr
    typedef struct packed {
        logic [2:0]  len;
        logic [31:0] tag;
        logic        route;
        logic        stall;
        logic        exp_mac;
    } entry_t;

    typedef struct packed {
        int                  pkt;
        int                  idx;
        logic                wend;
        loop_pkt_pkg::word_t data;
    } exp_word_t;

    logic                  clk_sys;
    logic                  rst;
    logic                  rlt_hd_wen;
    loop_pkt_pkg::hdr_t    rlt_hd_wdata;
    logic                  rlt_hd_afull;
    logic                  ve2ae_rd;
    loop_pkt_pkg::word_t   ve2ae_rdata;
    logic                  ve2ae_ef;
    loop_pkt_pkg::pkt_wr_t mac_wr;
    logic                  mac_aff;
    logic                  mac_rd;
    loop_pkt_pkg::word_t   mac_rdata;
    logic                  mac_ef;
    loop_pkt_pkg::pkt_wr_t ae2ve_wr;
    logic                  ae2ve_ff;
    logic                  loop_port_cfg;

    entry_t              tbl [NUM_PKTS];
    loop_pkt_pkg::word_t ve_q [$];
    loop_pkt_pkg::word_t mac_q [$];
    exp_word_t           exp_mac_q [$];
    exp_word_t           exp_res_q [$];
    integer              seed;
    logic                stall_on;
    int                  hdr_seen;
    int                  cycles;
    int                  cycle_limit;
    int                  word_errs;
    int                  bit_errs;
    int                  other_errs;

    loop_pkt_sch #(
        .LOOP_DEPTH    (64),
        .LOOP_AF_LEVEL (60),
        .HDR_DEPTH     (16),
        .HDR_AF_LEVEL  (12)
    ) dut (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .rlt_hd_wen    (rlt_hd_wen),
        .rlt_hd_wdata  (rlt_hd_wdata),
        .rlt_hd_afull  (rlt_hd_afull),
        .ve2ae_rd      (ve2ae_rd),
        .ve2ae_rdata   (ve2ae_rdata),
        .ve2ae_ef      (ve2ae_ef),
        .mac_wr        (mac_wr),
        .mac_aff       (mac_aff),
        .mac_rd        (mac_rd),
        .mac_rdata     (mac_rdata),
        .mac_ef        (mac_ef),
        .ae2ve_wr      (ae2ve_wr),
        .ae2ve_ff      (ae2ve_ff),
        .loop_port_cfg (loop_port_cfg)
    );

    always #4 clk_sys = ~clk_sys;

    // ========================================================================
    // reference helpers
    // ========================================================================
    // payload byte k moves to byte 63-k, sideband untouched
    function automatic loop_pkt_pkg::word_t reverse_bytes(input loop_pkt_pkg::word_t w);
        loop_pkt_pkg::word_t r;
        r = w;
        for (int b = 0; b < loop_pkt_pkg::DATA_BYTES * 8; b++) begin
            r[b] = w[(loop_pkt_pkg::DATA_BYTES - 1 - b / 8) * 8 + b % 8];
        end
        return r;
    endfunction

    function automatic loop_pkt_pkg::hdr_t header_of(input int n);
        return {4{tbl[n].tag, ~tbl[n].tag}};
    endfunction

    function automatic loop_pkt_pkg::word_t random_word(input logic last);
        loop_pkt_pkg::word_t w;
        logic [31:0]         r;
        for (int i = 0; i < 16; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        r = $random(seed);
        w[loop_pkt_pkg::WORD_W-1 -: loop_pkt_pkg::SIDE_W] = r[27:0];
        w[loop_pkt_pkg::EOP_BIT] = last;
        return w;
    endfunction

    task automatic compare_word(input string name, input loop_pkt_pkg::word_t exp,
                                input loop_pkt_pkg::word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            word_errs++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            bit_errs++;
        end
    endtask

    task automatic add_entry(input int n, input int len, input logic [31:0] tag,
                             input logic route, input logic stall, input logic exp_mac);
        entry_t e;
        e.len     = 3'(len);
        e.tag     = tag;
        e.route   = route;
        e.stall   = stall;
        e.exp_mac = exp_mac;
        tbl[n]    = e;
    endtask

    task automatic check_mac_word(input loop_pkt_pkg::pkt_wr_t wr);
        exp_word_t e;
        if (exp_mac_q.size() == 0) begin
            $display("word on mac_wr while no MAC packet was expected");
            other_errs++;
        end else begin
            e = exp_mac_q.pop_front();
            compare_word($sformatf("mac pkt %0d word %0d", e.pkt, e.idx), e.data, wr.wdata);
            compare_bit($sformatf("mac pkt %0d wend %0d", e.pkt, e.idx), e.wend, wr.wend);
        end
    endtask

    task automatic check_result_word(input loop_pkt_pkg::pkt_wr_t wr);
        exp_word_t e;
        if (exp_res_q.size() == 0) begin
            $display("word on ae2ve_wr while no result was expected");
            other_errs++;
        end else begin
            e = exp_res_q.pop_front();
            if (e.idx == 0) begin
                hdr_seen++;
            end
            compare_word($sformatf("res pkt %0d word %0d", e.pkt, e.idx), e.data, wr.wdata);
            compare_bit($sformatf("res pkt %0d wend %0d", e.pkt, e.idx), e.wend, wr.wend);
        end
    endtask

    // ========================================================================
    // queue models and monitors
    // ========================================================================
    always @(posedge clk_sys) begin
        if (!rst) begin
            if (ve2ae_rd) begin
                if (ve_q.size() == 0) begin
                    $display("VE queue read while it was empty");
                    other_errs++;
                end else begin
                    ve_q.delete(0);
                end
            end
            if (mac_wr.wen) begin
                mac_q.push_back(mac_wr.wdata);
                check_mac_word(mac_wr);
            end
            if (mac_rd) begin
                if (mac_q.size() == 0) begin
                    $display("MAC FIFO read while it was empty");
                    other_errs++;
                end else begin
                    mac_q.delete(0);
                end
            end
            if (ae2ve_wr.wen) begin
                check_result_word(ae2ve_wr);
            end
        end
    end

    always @(posedge clk_sys) begin
        #1;
        ve2ae_ef    = (ve_q.size() == 0);
        ve2ae_rdata = (ve_q.size() == 0) ? '0 : ve_q[0];
        mac_ef      = (mac_q.size() == 0);
        mac_rdata   = (mac_q.size() == 0) ? '0 : mac_q[0];
        mac_aff     = (mac_q.size() >= 12);
        ae2ve_ff    = stall_on && (($random(seed) & 1) != 0);
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run stopped, not finished within %0d cycles", cycle_limit);
            other_errs++;
            finish_run();
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic write_header(input loop_pkt_pkg::hdr_t h);
        rlt_hd_wen   = 1'b1;
        rlt_hd_wdata = h;
        next_cycle();
        rlt_hd_wen   = 1'b0;
    endtask

    task automatic run_packet(input int n);
        loop_pkt_pkg::word_t words [6];
        loop_pkt_pkg::word_t w;
        exp_word_t           e;
        logic                hold_eop;
        int                  len;
        len           = int'(tbl[n].len);
        stall_on      = tbl[n].stall;
        loop_port_cfg = (n + 1 < NUM_PKTS) ? tbl[n + 1].route : 1'b0;
        hold_eop      = (n + 1 < NUM_PKTS) && (tbl[n + 1].route != tbl[n].route);
        // header word comes first, zero sideband
        w      = '0;
        w[loop_pkt_pkg::HDR_W-1:0] = header_of(n);
        e.pkt  = n;
        e.idx  = 0;
        e.wend = 1'b0;
        e.data = reverse_bytes(w);
        exp_res_q.push_back(e);
        for (int i = 0; i < len; i++) begin
            words[i] = random_word(i == len - 1);
            e.idx    = i + 1;
            e.wend   = (i == len - 1);
            e.data   = words[i];
            exp_res_q.push_back(e);
            if (tbl[n].exp_mac) begin
                e.idx  = i;
                e.data = reverse_bytes(words[i]);
                exp_mac_q.push_back(e);
            end
        end
        for (int i = 0; i < len; i++) begin
            // lock flips on this eop, merge has to latch packet n first
            if (i == len - 1 && hold_eop) begin
                while (hdr_seen <= n) begin
                    next_cycle();
                end
            end
            ve_q.push_back(words[i]);
        end
        while (ve_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic wait_results();
        stall_on = 1'b0;
        while (exp_res_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic finish_run();
        $display("errors: word %0d, bit %0d, other %0d", word_errs, bit_errs, other_errs);
        if (word_errs + bit_errs + other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        int total;
        clk_sys       = 1'b0;
        rst           = 1'b1;
        rlt_hd_wen    = 1'b0;
        rlt_hd_wdata  = '0;
        ve2ae_rdata   = '0;
        ve2ae_ef      = 1'b1;
        mac_aff       = 1'b0;
        mac_rdata     = '0;
        mac_ef        = 1'b1;
        ae2ve_ff      = 1'b0;
        loop_port_cfg = 1'b0;
        seed          = 18622;
        stall_on      = 1'b0;
        hdr_seen      = 0;
        cycles        = 0;
        word_errs     = 0;
        bit_errs      = 0;
        other_errs    = 0;

        // n, len, tag, route, stall, exp_mac
        // a single-word packet never comes right before a route change
        add_entry(0,  3, 32'h1a2b_3c4d, 1'b0, 1'b0, 1'b0);
        add_entry(1,  1, 32'h0bad_f00d, 1'b0, 1'b0, 1'b0);
        add_entry(2,  4, 32'h7e57_0002, 1'b0, 1'b0, 1'b0);
        add_entry(3,  5, 32'hc0de_0003, 1'b1, 1'b0, 1'b1);
        add_entry(4,  2, 32'h9abc_0004, 1'b1, 1'b1, 1'b1);
        add_entry(5,  6, 32'h5555_aaa5, 1'b0, 1'b1, 1'b0);
        add_entry(6,  2, 32'h0123_4566, 1'b1, 1'b0, 1'b1);
        add_entry(7,  4, 32'hfeed_0007, 1'b0, 1'b0, 1'b0);
        add_entry(8,  6, 32'h8008_1358, 1'b1, 1'b1, 1'b1);
        add_entry(9,  6, 32'h2468_ace9, 1'b1, 1'b1, 1'b1);
        add_entry(10, 5, 32'hdead_000a, 1'b1, 1'b1, 1'b1);
        add_entry(11, 1, 32'h3141_592b, 1'b1, 1'b1, 1'b1);
        add_entry(12, 6, 32'h2718_281c, 1'b1, 1'b1, 1'b1);
        add_entry(13, 3, 32'h6a09_e66d, 1'b0, 1'b0, 1'b0);
        add_entry(14, 2, 32'hbb67_ae8e, 1'b0, 1'b1, 1'b0);
        add_entry(15, 1, 32'h3c6e_f37f, 1'b0, 1'b0, 1'b0);
        add_entry(16, 4, 32'ha54f_f530, 1'b0, 1'b1, 1'b0);
        add_entry(17, 6, 32'h510e_5271, 1'b1, 1'b1, 1'b1);
        add_entry(18, 3, 32'h9b05_6882, 1'b1, 1'b0, 1'b1);
        add_entry(19, 2, 32'h1f83_d9a3, 1'b0, 1'b0, 1'b0);

        total = 0;
        for (int n = 0; n < NUM_PKTS; n++) begin
            total += int'(tbl[n].len);
        end
        cycle_limit = 4 * total + 300;

        repeat (4) @(posedge clk_sys);
        #1;
        rst = 1'b0;
        next_cycle();

        // quiet outputs out of reset
        compare_bit("reset ve2ae_rd", 1'b0, ve2ae_rd);
        compare_bit("reset mac_wr.wen", 1'b0, mac_wr.wen);
        compare_bit("reset mac_wr.wend", 1'b0, mac_wr.wend);
        compare_bit("reset mac_rd", 1'b0, mac_rd);
        compare_bit("reset ae2ve_wr.wen", 1'b0, ae2ve_wr.wen);
        compare_bit("reset ae2ve_wr.wend", 1'b0, ae2ve_wr.wend);
        compare_bit("reset rlt_hd_afull", 1'b0, rlt_hd_afull);

        // one header per packet, fed in order
        for (int n = 0; n < NUM_PKTS - EARLY_HDR; n++) begin
            write_header(header_of(n));
            run_packet(n);
        end
        wait_results();

        // headers ahead of their packets fill the header fifo
        compare_bit("hdr afull before prefill", 1'b0, rlt_hd_afull);
        for (int n = NUM_PKTS - EARLY_HDR; n < NUM_PKTS; n++) begin
            write_header(header_of(n));
        end
        compare_bit("hdr afull after prefill", 1'b1, rlt_hd_afull);
        for (int n = NUM_PKTS - EARLY_HDR; n < NUM_PKTS; n++) begin
            run_packet(n);
        end
        wait_results();
        compare_bit("hdr afull after drain", 1'b0, rlt_hd_afull);

        if (exp_mac_q.size() != 0) begin
            $display("%0d expected MAC words never appeared", exp_mac_q.size());
            other_errs++;
        end
        if (mac_q.size() != 0) begin
            $display("MAC FIFO still holds %0d words at the end", mac_q.size());
            other_errs++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/loop_pkt_pkg.sv
logic/sync_fifo.sv
logic/tx_port_steer.sv
logic/rx_pkt_merge.sv
logic/loop_pkt_sch.sv
sim/loop_pkt_sch_checker.sv
sim/loop_pkt_sch_tb.sv

/* Bender.yml */
package:
  name: loop_pkt_sch

sources:
  # design, package first
  - logic/loop_pkt_pkg.sv
  - logic/sync_fifo.sv
  - logic/tx_port_steer.sv
  - logic/rx_pkt_merge.sv
  - logic/loop_pkt_sch.sv

  # testbench and bound checker
  - target: simulation
    files:
      - sim/loop_pkt_sch_checker.sv
      - sim/loop_pkt_sch_tb.sv
